// ==== src/proc_settings.svh ====
// Sizing macros shared by every block of the 16-bit pipelined core
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// Machine word
`define DATA_WIDTH 16

// Words in each of the instruction and data memories
`define MEM_DEPTH 256

// Eight architectural registers
`define REG_BITS 3

`endif

// ==== src/procPkg.sv ====
// Types shared across the pipeline: opcodes, instruction fields, stage registers
`include "proc_settings.svh"

package procPkg;

   typedef logic [`DATA_WIDTH-1:0] wordT;
   typedef logic [`REG_BITS-1:0] regIdxT;
   typedef logic [$clog2(`MEM_DEPTH)-1:0] memAddrT;

   // Instruction bits 15:11, anything else is illegal
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAdd  = 5'b11011,
      opSub  = 5'b11100,   // rd = rs - rt
      opAnd  = 5'b11101,
      opXor  = 5'b11110
   } opcodeT;

   // Register ops
   typedef struct packed {
      opcodeT op;
      regIdxT rs;
      regIdxT rt;
      regIdxT rd;
      logic [1:0] pad;
   } rFmtT;

   // ADDI, LD, ST. rd is the load target or the store source
   typedef struct packed {
      opcodeT op;
      regIdxT rs;
      regIdxT rd;
      logic [4:0] imm5;
   } iFmtT;

   // LBI and BEQZ
   typedef struct packed {
      opcodeT op;
      regIdxT rs;
      logic [7:0] imm8;
   } bFmtT;

   typedef struct packed {
      opcodeT op;
      logic [10:0] imm11;
   } jFmtT;

   // Targets are PC+1 plus the signed offset, PC counts words
   typedef union packed {
      rFmtT r;
      iFmtT i;
      bFmtT b;
      jFmtT j;
   } instrFormat;

   typedef enum logic [1:0] {fromReg, fromXm, fromMw} fwdSelT;

   typedef struct packed {
      logic valid;
      wordT pc;
      instrFormat instr;
   } fdRegT;

   typedef struct packed {
      logic valid;
      opcodeT op;
      wordT rsVal;
      wordT rtVal;
      regIdxT rsIdx;
      regIdxT rtIdx;
      wordT imm;
      wordT pc;
      regIdxT writeReg;
      logic regWrite;
      logic memRead;
      logic memWrite;
      logic halt;
   } dxRegT;

   typedef struct packed {
      logic valid;
      wordT aluResult;
      wordT storeData;
      regIdxT writeReg;
      logic regWrite;
      logic memRead;
      logic memWrite;
      logic halt;
   } xmRegT;

   // Commit record
   typedef struct packed {
      logic valid;
      regIdxT writeReg;
      logic regWrite;
      wordT result;
      logic halt;
   } mwRegT;

endpackage

// ==== src/fetch.sv ====
// Fetch stage holding the PC, the loadable instruction memory and the FD register
`include "proc_settings.svh"

module fetch (
   input  logic clk,
   input  logic rst,
   input  logic imemWrEn,
   input  procPkg::memAddrT imemAddr,
   input  procPkg::wordT imemData,
   input  logic stall,
   input  logic flush,
   input  logic redirect,
   input  procPkg::wordT redirectPc,
   output procPkg::fdRegT fdReg
);
   import procPkg::*;

   wordT imem [`MEM_DEPTH];
   wordT pc;
   wordT pcNext;
   logic haltHold;
   logic fdHalt;
   logic haltNow;

   // Program image only arrives through the load port
   always_ff @(posedge clk) begin
      if (imemWrEn) begin
         imem[imemAddr] <= imemData;
      end
   end

   // A HALT sitting in decode freezes the front end
   assign fdHalt = fdReg.valid && (fdReg.instr.r.op == opHalt);
   assign haltNow = fdHalt || haltHold;

   always_comb begin
      if (redirect) begin
         pcNext = redirectPc;
      end else if (stall || haltNow) begin
         pcNext = pc;
      end else begin
         pcNext = pc + wordT'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
         haltHold <= 1'b0;
      end else begin
         pc <= pcNext;
         // Squashed HALT lets fetch run again
         if (flush) begin
            haltHold <= 1'b0;
         end else if (fdHalt) begin
            haltHold <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         fdReg.valid <= 1'b0;
      end else if (flush || (haltNow && !stall)) begin
         fdReg.valid <= 1'b0;
      end else if (!stall) begin
         fdReg.valid <= 1'b1;
         fdReg.pc <= pc;
         fdReg.instr <= imem[memAddrT'(pc)];
      end
   end

   // Loading is only legal while the core is held in reset
   assert property (@(posedge clk) !rst |-> !imemWrEn)
      else $error("instruction memory written outside reset");

endmodule

// ==== src/decode.sv ====
// Decode stage with control decode, immediates, register file and DX register
`include "proc_settings.svh"

module decode (
   input  logic clk,
   input  logic rst,
   input  procPkg::fdRegT fdReg,
   input  logic stall,
   input  logic flush,
   input  procPkg::mwRegT mwReg,
   output procPkg::dxRegT dxReg,
   output logic haltSeen,
   output logic err
);
   import procPkg::*;

   wordT regs [1 << `REG_BITS];
   dxRegT dxNext;
   logic illegal;

   // Same-cycle write-back is visible to the read
   function automatic wordT readReg(input regIdxT idx);
      if (mwReg.valid && mwReg.regWrite && (mwReg.writeReg == idx)) begin
         return mwReg.result;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge clk) begin
      if (mwReg.valid && mwReg.regWrite) begin
         regs[mwReg.writeReg] <= mwReg.result;
      end
   end

   always_comb begin
      dxNext = '0;
      illegal = 1'b0;
      dxNext.valid = fdReg.valid;
      dxNext.pc = fdReg.pc;
      dxNext.op = fdReg.instr.r.op;
      dxNext.rsIdx = fdReg.instr.r.rs;
      dxNext.rtIdx = fdReg.instr.r.rt;
      dxNext.rsVal = readReg(fdReg.instr.r.rs);
      dxNext.rtVal = readReg(fdReg.instr.r.rt);
      case (fdReg.instr.r.op)
         opAdd, opSub, opAnd, opXor: begin
            dxNext.writeReg = fdReg.instr.r.rd;
            dxNext.regWrite = 1'b1;
         end
         opAddi, opLd: begin
            dxNext.writeReg = fdReg.instr.i.rd;
            dxNext.regWrite = 1'b1;
            dxNext.memRead = (fdReg.instr.r.op == opLd);
            dxNext.imm = {{(`DATA_WIDTH-5){fdReg.instr.i.imm5[4]}}, fdReg.instr.i.imm5};
         end
         opSt: begin
            dxNext.memWrite = 1'b1;
            dxNext.imm = {{(`DATA_WIDTH-5){fdReg.instr.i.imm5[4]}}, fdReg.instr.i.imm5};
         end
         opLbi: begin
            // LBI targets its own rs field
            dxNext.writeReg = fdReg.instr.b.rs;
            dxNext.regWrite = 1'b1;
            dxNext.imm = {{(`DATA_WIDTH-8){fdReg.instr.b.imm8[7]}}, fdReg.instr.b.imm8};
         end
         opBeqz: begin
            dxNext.imm = {{(`DATA_WIDTH-8){fdReg.instr.b.imm8[7]}}, fdReg.instr.b.imm8};
         end
         opJ: begin
            dxNext.imm = {{(`DATA_WIDTH-11){fdReg.instr.j.imm11[10]}}, fdReg.instr.j.imm11};
         end
         opHalt: begin
            dxNext.halt = 1'b1;
         end
         opNop: begin
            dxNext.halt = 1'b0;
         end
         default: begin
            // Unknown code travels on as a NOP
            illegal = 1'b1;
            dxNext.op = opNop;
         end
      endcase
   end

   assign haltSeen = fdReg.valid && (fdReg.instr.r.op == opHalt);
   assign err = fdReg.valid && illegal && !flush;

   // Stall and flush both leave a bubble behind
   always_ff @(posedge clk) begin
      if (rst) begin
         dxReg.valid <= 1'b0;
      end else if (stall || flush) begin
         dxReg.valid <= 1'b0;
      end else begin
         dxReg <= dxNext;
      end
   end

   // r0 only changes through a committed register write
   assert property (@(posedge clk) disable iff (rst)
      !$stable(regs[0]) |->
         $past(mwReg.valid && mwReg.regWrite && (mwReg.writeReg == '0)))
      else $error("register 0 changed without a write-back");

endmodule

// ==== src/hazardUnit.sv ====
// Hazard unit for operand forwarding, load-use stall and redirect flush
module hazardUnit (
   input  procPkg::fdRegT fdReg,
   input  procPkg::dxRegT dxReg,
   input  procPkg::xmRegT xmReg,
   input  procPkg::mwRegT mwReg,
   input  logic redirect,
   output procPkg::fwdSelT fwdA,
   output procPkg::fwdSelT fwdB,
   output logic stall,
   output logic flush
);
   import procPkg::*;

   logic loadInDx;

   // Newest producer wins and a load in xm has no data yet
   function automatic fwdSelT pickSource(input regIdxT src);
      if (xmReg.valid && xmReg.regWrite && !xmReg.memRead && (xmReg.writeReg == src)) begin
         return fromXm;
      end
      if (mwReg.valid && mwReg.regWrite && (mwReg.writeReg == src)) begin
         return fromMw;
      end
      return fromReg;
   endfunction

   always_comb begin
      fwdA = pickSource(dxReg.rsIdx);
      fwdB = pickSource(dxReg.rtIdx);
   end

   // Load result against both source fields of the instruction in decode
   assign loadInDx = dxReg.valid && dxReg.memRead;
   assign stall = loadInDx && fdReg.valid &&
                  ((dxReg.writeReg == fdReg.instr.r.rs) ||
                   (dxReg.writeReg == fdReg.instr.r.rt));

   assign flush = redirect;

   // A load in execute never redirects
   always_comb begin
      assert (!(stall && flush))
         else $error("stall and flush raised together");
   end

endmodule

// ==== src/execute.sv ====
// Execute stage with forwarding muxes, ALU, branch resolution and XM register
`include "proc_settings.svh"

module execute (
   input  logic clk,
   input  logic rst,
   input  procPkg::dxRegT dxReg,
   input  procPkg::fwdSelT fwdA,
   input  procPkg::fwdSelT fwdB,
   input  procPkg::wordT xmResult,
   input  procPkg::wordT mwResult,
   output procPkg::xmRegT xmReg,
   output logic redirect,
   output procPkg::wordT redirectPc,
   output logic err
);
   import procPkg::*;

   wordT opA;
   wordT opB;
   wordT aluResult;
   xmRegT xmNext;

   function automatic wordT pickOperand(input fwdSelT sel, input wordT regVal);
      case (sel)
         fromXm:  return xmResult;
         fromMw:  return mwResult;
         default: return regVal;
      endcase
   endfunction

   always_comb begin
      opA = pickOperand(fwdA, dxReg.rsVal);
      opB = pickOperand(fwdB, dxReg.rtVal);
   end

   always_comb begin
      case (dxReg.op)
         opAdd:              aluResult = opA + opB;
         opSub:              aluResult = opA - opB;
         opAnd:              aluResult = opA & opB;
         opXor:              aluResult = opA ^ opB;
         opAddi, opLd, opSt: aluResult = opA + dxReg.imm;   // also address generation
         opLbi:              aluResult = dxReg.imm;
         default:            aluResult = '0;
      endcase
   end

   // Branch and jump resolve here
   assign redirectPc = dxReg.pc + wordT'(1) + dxReg.imm;
   assign redirect = dxReg.valid &&
                     (((dxReg.op == opBeqz) && (opA == '0)) || (dxReg.op == opJ));

   // Address past the end of data memory
   assign err = dxReg.valid && (dxReg.memRead || dxReg.memWrite) &&
                (aluResult >= wordT'(`MEM_DEPTH));

   always_comb begin
      xmNext.valid = dxReg.valid;
      xmNext.aluResult = aluResult;
      xmNext.storeData = opB;
      xmNext.writeReg = dxReg.writeReg;
      xmNext.regWrite = dxReg.regWrite;
      xmNext.memRead = dxReg.memRead;
      xmNext.memWrite = dxReg.memWrite;
      xmNext.halt = dxReg.halt;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         xmReg.valid <= 1'b0;
      end else begin
         xmReg <= xmNext;
      end
   end

endmodule

// ==== src/memory.sv ====
// Memory stage with data memory, write-back result select and MW register
`include "proc_settings.svh"

module memory (
   input  logic clk,
   input  logic rst,
   input  procPkg::xmRegT xmReg,
   output procPkg::mwRegT mwReg
);
   import procPkg::*;

   wordT dmem [`MEM_DEPTH];
   memAddrT addr;
   wordT loadWord;

   // Upper address bits are caught as an error in execute
   assign addr = memAddrT'(xmReg.aluResult);
   assign loadWord = dmem[addr];

   always_ff @(posedge clk) begin
      if (xmReg.valid && xmReg.memWrite) begin
         dmem[addr] <= xmReg.storeData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mwReg.valid <= 1'b0;
      end else begin
         mwReg.valid <= xmReg.valid;
         mwReg.writeReg <= xmReg.writeReg;
         mwReg.regWrite <= xmReg.regWrite;
         mwReg.halt <= xmReg.halt;
         // Loaded word or ALU value goes to write-back
         mwReg.result <= xmReg.memRead ? loadWord : xmReg.aluResult;
      end
   end

endmodule

// ==== src/proc.sv ====
// Top level of the five-stage 16-bit pipelined core
module proc (
   input  logic clk,
   input  logic rst,
   input  logic imemWrEn,
   input  procPkg::memAddrT imemAddr,
   input  procPkg::wordT imemData,
   output logic commitValid,
   output procPkg::regIdxT commitReg,
   output procPkg::wordT commitData,
   output logic halted,
   output logic err
);
   import procPkg::*;

   fdRegT fdReg;
   dxRegT dxReg;
   xmRegT xmReg;
   mwRegT mwReg;
   fwdSelT fwdA;
   fwdSelT fwdB;
   wordT redirectPc;
   logic stall;
   logic flush;
   logic redirect;
   logic haltSeen;
   logic decodeErr;
   logic executeErr;
   logic haltedQ;
   logic haltInMw;

   fetch fetch_i (
      .clk(clk), .rst(rst),
      .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
      .stall(stall), .flush(flush),
      .redirect(redirect), .redirectPc(redirectPc),
      .fdReg(fdReg)
   );

   decode decode_i (
      .clk(clk), .rst(rst),
      .fdReg(fdReg), .stall(stall), .flush(flush), .mwReg(mwReg),
      .dxReg(dxReg), .haltSeen(haltSeen), .err(decodeErr)
   );

   hazardUnit hazardUnit_i (
      .fdReg(fdReg), .dxReg(dxReg), .xmReg(xmReg), .mwReg(mwReg),
      .redirect(redirect),
      .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
   );

   execute execute_i (
      .clk(clk), .rst(rst),
      .dxReg(dxReg), .fwdA(fwdA), .fwdB(fwdB),
      .xmResult(xmReg.aluResult), .mwResult(mwReg.result),
      .xmReg(xmReg), .redirect(redirect), .redirectPc(redirectPc),
      .err(executeErr)
   );

   memory memory_i (
      .clk(clk), .rst(rst),
      .xmReg(xmReg), .mwReg(mwReg)
   );

   // Commit port follows write-back
   assign commitValid = mwReg.valid && mwReg.regWrite;
   assign commitReg = mwReg.writeReg;
   assign commitData = mwReg.result;

   assign haltInMw = mwReg.valid && mwReg.halt;
   assign halted = haltedQ || haltInMw;

   // Both flags stick until the next reset
   always_ff @(posedge clk) begin
      if (rst) begin
         haltedQ <= 1'b0;
         err <= 1'b0;
      end else begin
         haltedQ <= halted;
         err <= err || decodeErr || executeErr;
      end
   end

   // An unsquashed HALT leaving decode reaches write-back three edges later
   assert property (@(posedge clk) disable iff (rst)
      (haltSeen && !stall && !flush) |-> ##3 halted)
      else $error("decoded HALT did not reach write-back");

endmodule

// ==== verification/procTb.sv ====
// Directed testbench for the pipelined core that loads programs and checks the commit stream
module procTb;
   import procPkg::*;

   localparam int TestLimit = 300;
   localparam int TotalLimit = 6 * TestLimit;
   localparam int ResetCycles = 8;

   typedef struct packed {
      regIdxT idx;
      wordT value;
   } commitRecT;

   logic clk;
   logic rst;
   logic imemWrEn;
   memAddrT imemAddr;
   wordT imemData;
   logic commitValid;
   regIdxT commitReg;
   wordT commitData;
   logic halted;
   logic err;

   wordT prog[$];
   commitRecT gotQ[$];
   commitRecT expQ[$];
   int cycleCount = 0;
   int errorCount = 0;
   int failedTests = 0;

   proc proc_i (
      .clk(clk), .rst(rst),
      .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
      .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData),
      .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
   end

   // Whole-run watchdog
   initial begin
      wait (cycleCount >= TotalLimit);
      $display("Timeout: run did not finish within %0d cycles", TotalLimit);
      $display("Simulation FAILED");
      $finish;
   end

   // Instruction encoders, field layout as in the ISA
   function automatic wordT encR(opcodeT op, regIdxT rs, regIdxT rt, regIdxT rd);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   function automatic wordT encI(opcodeT op, regIdxT rs, regIdxT rd, logic [4:0] imm5);
      return {op, rs, rd, imm5};
   endfunction

   function automatic wordT encB(opcodeT op, regIdxT rs, logic [7:0] imm8);
      return {op, rs, imm8};
   endfunction

   function automatic wordT encJ(opcodeT op, logic [10:0] imm11);
      return {op, imm11};
   endfunction

   task automatic expectCommit(input regIdxT idx, input wordT value);
      commitRecT rec;
      rec.idx = idx;
      rec.value = value;
      expQ.push_back(rec);
   endtask

   // Program goes in while reset is high, at least eight reset cycles
   task automatic resetAndLoad();
      int loadCycles;
      loadCycles = (prog.size() > ResetCycles) ? prog.size() : ResetCycles;
      @(negedge clk);
      rst = 1'b1;
      for (int i = 0; i < loadCycles; i++) begin
         imemAddr = memAddrT'(i);
         if (i < prog.size()) begin
            imemWrEn = 1'b1;
            imemData = prog[i];
         end else begin
            imemWrEn = 1'b0;
            imemData = '0;
         end
         @(negedge clk);
      end
      rst = 1'b0;
      imemWrEn = 1'b0;
      assert (!commitValid && !halted && !err) else begin
         $display("Outputs not cleared by reset at %0t", $time);
         errorCount++;
      end
      expQ.delete();
   endtask

   // Collect commits until halted, err must stay high once set
   task automatic runToHalt(input int testStart);
      commitRecT rec;
      logic errSeen;
      logic done;
      errSeen = 1'b0;
      done = 1'b0;
      gotQ.delete();
      while (!done) begin
         @(negedge clk);
         if (commitValid) begin
            rec.idx = commitReg;
            rec.value = commitData;
            gotQ.push_back(rec);
         end
         assert (!(errSeen && !err)) else begin
            $display("err dropped back to low at %0t without a reset", $time);
            errorCount++;
         end
         if (err) begin
            errSeen = 1'b1;
         end
         if (halted) begin
            done = 1'b1;
         end else if (cycleCount - testStart >= TestLimit) begin
            $display("Timeout: no HALT within %0d cycles at %0t", TestLimit, $time);
            errorCount++;
            done = 1'b1;
         end
      end
   endtask

   task automatic compareCommits();
      assert (gotQ.size() == expQ.size()) else begin
         $display("Mismatch at %0t: commit count got %0d expected %0d",
                  $time, gotQ.size(), expQ.size());
         errorCount++;
      end
      for (int i = 0; i < gotQ.size() && i < expQ.size(); i++) begin
         assert (gotQ[i].idx == expQ[i].idx) else begin
            $display("Mismatch at %0t: commitReg[%0d] got %0d expected %0d",
                     $time, i, gotQ[i].idx, expQ[i].idx);
            errorCount++;
         end
         assert (gotQ[i].value == expQ[i].value) else begin
            $display("Mismatch at %0t: commitData[%0d] got %h expected %h",
                     $time, i, gotQ[i].value, expQ[i].value);
            errorCount++;
         end
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         errorCount++;
      end
   endtask

   task automatic reportTest(input string name, input int startErrors);
      if (errorCount == startErrors) begin
         $display("Test %s ok", name);
      end else begin
         $display("Test %s failed with %0d errors", name, errorCount - startErrors);
         failedTests++;
      end
   endtask

   // Each result feeds the next, exercises xm and mw forwarding
   task automatic aluChainTest();
      int startErrors;
      int testStart;
      logic [4:0] a;
      logic [7:0] b;
      wordT r1, r2, r3, r4, r5, r6;
      startErrors = errorCount;
      testStart = cycleCount;
      a = 5'($urandom());
      b = 8'($urandom());
      prog.delete();
      prog.push_back(encB(opLbi, 3'd1, b));
      prog.push_back(encI(opAddi, 3'd1, 3'd2, a));
      prog.push_back(encR(opAdd, 3'd2, 3'd1, 3'd3));
      prog.push_back(encR(opSub, 3'd3, 3'd2, 3'd4));
      prog.push_back(encR(opAnd, 3'd4, 3'd3, 3'd5));
      prog.push_back(encR(opXor, 3'd5, 3'd4, 3'd6));
      prog.push_back(encJ(opHalt, 11'd0));
      resetAndLoad();
      r1 = {{8{b[7]}}, b};
      r2 = r1 + {{11{a[4]}}, a};
      r3 = r2 + r1;
      r4 = r3 - r2;
      r5 = r4 & r3;
      r6 = r5 ^ r4;
      expectCommit(3'd1, r1);
      expectCommit(3'd2, r2);
      expectCommit(3'd3, r3);
      expectCommit(3'd4, r4);
      expectCommit(3'd5, r5);
      expectCommit(3'd6, r6);
      runToHalt(testStart);
      compareCommits();
      checkBit("err", err, 1'b0);
      reportTest("aluChain", startErrors);
   endtask

   // Load result used right away, needs the one-cycle stall
   task automatic storeLoadTest();
      int startErrors;
      int testStart;
      logic [7:0] v;
      wordT stored;
      startErrors = errorCount;
      testStart = cycleCount;
      v = 8'($urandom());
      stored = {{8{v[7]}}, v};
      prog.delete();
      prog.push_back(encB(opLbi, 3'd1, 8'd5));
      prog.push_back(encB(opLbi, 3'd2, v));
      prog.push_back(encI(opSt, 3'd1, 3'd2, 5'd3));
      prog.push_back(encI(opLd, 3'd1, 3'd3, 5'd3));
      prog.push_back(encR(opAdd, 3'd3, 3'd1, 3'd4));
      prog.push_back(encJ(opHalt, 11'd0));
      resetAndLoad();
      expectCommit(3'd1, 16'd5);
      expectCommit(3'd2, stored);
      expectCommit(3'd3, stored);
      expectCommit(3'd4, stored + 16'd5);
      runToHalt(testStart);
      compareCommits();
      checkBit("err", err, 1'b0);
      reportTest("storeLoad", startErrors);
   endtask

   // Not taken at pc 2, taken at pc 5 to 5+1+2
   task automatic branchTest();
      int startErrors;
      int testStart;
      startErrors = errorCount;
      testStart = cycleCount;
      prog.delete();
      prog.push_back(encB(opLbi, 3'd1, 8'd0));
      prog.push_back(encB(opLbi, 3'd2, 8'd7));
      prog.push_back(encB(opBeqz, 3'd2, 8'd2));
      prog.push_back(encB(opLbi, 3'd3, 8'h11));
      prog.push_back(encB(opLbi, 3'd4, 8'h22));
      prog.push_back(encB(opBeqz, 3'd1, 8'd2));
      prog.push_back(encB(opLbi, 3'd5, 8'h33));
      prog.push_back(encB(opLbi, 3'd6, 8'h44));
      prog.push_back(encB(opLbi, 3'd7, 8'h55));
      prog.push_back(encJ(opHalt, 11'd0));
      resetAndLoad();
      expectCommit(3'd1, 16'h0000);
      expectCommit(3'd2, 16'h0007);
      expectCommit(3'd3, 16'h0011);
      expectCommit(3'd4, 16'h0022);
      expectCommit(3'd7, 16'h0055);
      runToHalt(testStart);
      compareCommits();
      checkBit("err", err, 1'b0);
      reportTest("branch", startErrors);
   endtask

   // J at pc 1 lands on 1+1+3, skipping three words
   task automatic jumpTest();
      int startErrors;
      int testStart;
      startErrors = errorCount;
      testStart = cycleCount;
      prog.delete();
      prog.push_back(encB(opLbi, 3'd1, 8'hFD));
      prog.push_back(encJ(opJ, 11'd3));
      prog.push_back(encB(opLbi, 3'd2, 8'h01));
      prog.push_back(encB(opLbi, 3'd3, 8'h02));
      prog.push_back(encB(opLbi, 3'd4, 8'h03));
      prog.push_back(encI(opAddi, 3'd1, 3'd5, 5'b11100));
      prog.push_back(encB(opLbi, 3'd6, 8'h80));
      prog.push_back(encJ(opHalt, 11'd0));
      resetAndLoad();
      // -3, then -3 + -4, then -128
      expectCommit(3'd1, 16'hFFFD);
      expectCommit(3'd5, 16'hFFF9);
      expectCommit(3'd6, 16'hFF80);
      runToHalt(testStart);
      compareCommits();
      checkBit("err", err, 1'b0);
      reportTest("jump", startErrors);
   endtask

   task automatic haltTest();
      int startErrors;
      int testStart;
      startErrors = errorCount;
      testStart = cycleCount;
      prog.delete();
      prog.push_back(encB(opLbi, 3'd1, 8'h0A));
      prog.push_back(encI(opAddi, 3'd1, 3'd2, 5'd1));
      prog.push_back(encJ(opHalt, 11'd0));
      prog.push_back(encB(opLbi, 3'd3, 8'h77));
      prog.push_back(encB(opLbi, 3'd4, 8'h66));
      resetAndLoad();
      expectCommit(3'd1, 16'h000A);
      expectCommit(3'd2, 16'h000B);
      runToHalt(testStart);
      compareCommits();
      // Quiet window after halt
      repeat (8) begin
         @(negedge clk);
         assert (!commitValid) else begin
            $display("Commit to r%0d seen after HALT at %0t", commitReg, $time);
            errorCount++;
         end
         checkBit("halted", halted, 1'b1);
      end
      reportTest("halt", startErrors);
   endtask

   task automatic illegalOpTest();
      int startErrors;
      int testStart;
      startErrors = errorCount;
      testStart = cycleCount;
      prog.delete();
      prog.push_back(encB(opLbi, 3'd1, 8'd1));
      prog.push_back(16'h1000);
      prog.push_back(encB(opLbi, 3'd2, 8'd2));
      prog.push_back(encJ(opHalt, 11'd0));
      resetAndLoad();
      expectCommit(3'd1, 16'd1);
      expectCommit(3'd2, 16'd2);
      runToHalt(testStart);
      compareCommits();
      checkBit("err", err, 1'b1);
      // Clean program after a fresh reset
      prog.delete();
      prog.push_back(encB(opLbi, 3'd1, 8'd3));
      prog.push_back(encI(opAddi, 3'd1, 3'd2, 5'd2));
      prog.push_back(encJ(opHalt, 11'd0));
      resetAndLoad();
      expectCommit(3'd1, 16'd3);
      expectCommit(3'd2, 16'd5);
      runToHalt(testStart);
      compareCommits();
      checkBit("err", err, 1'b0);
      reportTest("illegalOp", startErrors);
   endtask

   initial begin
      rst = 1'b1;
      imemWrEn = 1'b0;
      imemAddr = '0;
      imemData = '0;
      void'($urandom(29));
      aluChainTest();
      storeLoadTest();
      branchTest();
      jumpTest();
      haltTest();
      illegalOpTest();
      $display("Tests run 6, tests failed %0d, checks failed %0d", failedTests, errorCount);
      if (errorCount == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+src
src/procPkg.sv
src/fetch.sv
src/decode.sv
src/hazardUnit.sv
src/execute.sv
src/memory.sv
src/proc.sv
verification/procTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -euo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f tb.f \
   --top-module procTb \
   --Mdir obj_dir \
   -o procSim

./obj_dir/procSim 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
   echo "Run failed, see sim.log"
   exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
   echo "Run ended without a result, see sim.log"
   exit 1
fi
echo "Run passed"
